/* Makefile */
# Verilator build and run for the check node testbench

SRCS := check_node.f $(wildcard logic/*.sv) $(wildcard testbench/*.sv) \
        $(wildcard testbench/*.svh)

obj_dir/Vtb_check_node_unit: $(SRCS)
	verilator --binary --timing --assert -j 0 -f check_node.f \
		--top-module tb_check_node_unit -o Vtb_check_node_unit

run: obj_dir/Vtb_check_node_unit
	./obj_dir/Vtb_check_node_unit | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* check_node.f */
+incdir+testbench
logic/check_node_pkg.sv
logic/cn_min_merge.sv
logic/cn_min_tree.sv
logic/cn_edge_update.sv
logic/check_node_unit.sv
testbench/tb_check_node_unit.sv

/* logic/check_node_pkg.sv */
// Shared widths and message types for the min-sum check node.
// Messages are sign-magnitude, and a set sign bit means negative.
// The degree is fixed at six edges, taken as three pairs of two.

package check_node_pkg;

    //////////////////////////////
    // widths and sizes
    //////////////////////////////

    // magnitude bits of one message
    localparam int MAG_W = 5;

    // edges on one check node
    localparam int CN_DEGREE = 6;

    // wide enough to name any edge
    localparam int IDX_W = 3;

    // first stage sorts edges two at a time
    localparam int NUM_PAIRS = CN_DEGREE / 2;

    // subtracted from every outgoing magnitude
    localparam logic [MAG_W-1:0] NORM_OFFSET_DEFAULT = 5'd1;

    //////////////////////////////
    // message types
    //////////////////////////////

    typedef struct packed {
        logic             sign;
        logic [MAG_W-1:0] mag;
    } llr_t;

    // edge 0 sits in the lowest bits
    typedef llr_t [CN_DEGREE-1:0] llr_vec_t;

    // partial result of a minimum search
    typedef struct packed {
        logic [MAG_W-1:0] min1;
        logic [MAG_W-1:0] min2;
        logic [IDX_W-1:0] idx;
    } min_pair_t;

    // left covers edges 0 to 3, right covers edges 4 and 5
    typedef struct packed {
        min_pair_t            left;
        min_pair_t            right;
        logic [CN_DEGREE-1:0] sign_vec;
        logic                 sign_par_left;
        logic                 sign_par_right;
        logic                 hard_par_left;
        logic                 hard_par_right;
    } tree_out_t;

endpackage

/* logic/check_node_unit.sv */
// Min-sum check node with six edges and three pipeline stages.
// Outputs update two cycles after the edge that samples en_in high.
// No back-pressure, so every enabled cycle yields one out_valid pulse.

`timescale 1ns/1ps

module check_node_unit #(
    parameter logic [check_node_pkg::MAG_W-1:0] norm_offset =
        check_node_pkg::NORM_OFFSET_DEFAULT
) (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 en_in,
    input  check_node_pkg::llr_vec_t             din,
    input  logic [check_node_pkg::CN_DEGREE-1:0] hard_bits,
    output check_node_pkg::llr_vec_t             dout,
    output logic                                 check_parity,
    output logic                                 out_valid
);
    import check_node_pkg::*;

    tree_out_t tree_out;
    logic      tree_valid;

    //////////////////////////////
    // sort and merge stages
    //////////////////////////////

    cn_min_tree u_min_tree (
        .clk        (clk),
        .reset_n    (reset_n),
        .en_in      (en_in),
        .din        (din),
        .hard_bits  (hard_bits),
        .tree_out   (tree_out),
        .tree_valid (tree_valid)
    );

    //////////////////////////////
    // outgoing messages
    //////////////////////////////

    cn_edge_update #(
        .norm_offset (norm_offset)
    ) u_edge_update (
        .clk          (clk),
        .reset_n      (reset_n),
        .tree_out     (tree_out),
        .tree_valid   (tree_valid),
        .dout         (dout),
        .check_parity (check_parity),
        .out_valid    (out_valid)
    );

endmodule

/* logic/cn_edge_update.sv */
// Last pipeline stage. It turns the tree result into the outgoing messages.
// The offset saturates at zero and is applied to every edge.
// dout and check_parity hold their values between valid sets.

`timescale 1ns/1ps

module cn_edge_update #(
    parameter logic [check_node_pkg::MAG_W-1:0] norm_offset =
        check_node_pkg::NORM_OFFSET_DEFAULT
) (
    input  logic                      clk,
    input  logic                      reset_n,
    input  check_node_pkg::tree_out_t tree_out,
    input  logic                      tree_valid,
    output check_node_pkg::llr_vec_t  dout,
    output logic                      check_parity,
    output logic                      out_valid
);
    import check_node_pkg::*;

    min_pair_t                        final_min;
    logic [CN_DEGREE-1:0][MAG_W-1:0]  mag_sel;
    logic                             total_sign;
    llr_vec_t                         dout_d;

    //////////////////////////////
    // final minimum
    //////////////////////////////

    cn_min_merge u_merge_final (
        .left   (tree_out.left),
        .right  (tree_out.right),
        .merged (final_min)
    );

    // product of all six signs
    assign total_sign = tree_out.sign_par_left ^ tree_out.sign_par_right;

    //////////////////////////////
    // per-edge message
    //////////////////////////////

    always_comb begin
        for (int e = 0; e < CN_DEGREE; e++) begin
            // the min1 edge sees the rest, so it takes min2
            if (final_min.idx == IDX_W'(e)) begin
                mag_sel[e] = final_min.min2;
            end else begin
                mag_sel[e] = final_min.min1;
            end

            if (mag_sel[e] > norm_offset) begin
                dout_d[e].mag = mag_sel[e] - norm_offset;
            end else begin
                dout_d[e].mag = '0;
            end

            // drop the edge's own sign from the product
            dout_d[e].sign = total_sign ^ tree_out.sign_vec[e];
        end
    end

    //////////////////////////////
    // output registers
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            dout         <= '0;
            check_parity <= 1'b0;
        end else if (tree_valid) begin
            dout         <= dout_d;
            check_parity <= tree_out.hard_par_left ^ tree_out.hard_par_right;
        end
    end

    // one pulse per set, last tap of the enable chain
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= tree_valid;
        end
    end

endmodule

/* logic/cn_min_merge.sv */
// Purely combinational merge of two partial minimum results.
// The left operand wins a tie, so its index is kept on equal minima.
// Each input must already hold min1 <= min2.

`timescale 1ns/1ps

module cn_min_merge (
    input  check_node_pkg::min_pair_t left,
    input  check_node_pkg::min_pair_t right,
    output check_node_pkg::min_pair_t merged
);
    import check_node_pkg::*;

    min_pair_t winner;
    min_pair_t loser;
    logic      right_wins;

    //////////////////////////////
    // pick the smaller min1
    //////////////////////////////

    // strict compare keeps ties on the left
    assign right_wins = (right.min1 < left.min1);

    always_comb begin
        if (right_wins) begin
            winner = right;
            loser  = left;
        end else begin
            winner = left;
            loser  = right;
        end
    end

    //////////////////////////////
    // second minimum
    //////////////////////////////

    // loser min1 competes with winner min2 for second place
    always_comb begin
        merged.min1 = winner.min1;
        merged.idx  = winner.idx;
        if (loser.min1 < winner.min2) begin
            merged.min2 = loser.min1;
        end else begin
            merged.min2 = winner.min2;
        end
    end

endmodule

/* logic/cn_min_tree.sv */
// First two pipeline stages of the check node.
// A new set may enter on every cycle where en_in is high, with no stall.
// Stage 1 loads only while en_in is high and stage 2 only on the delayed
// enable, so between sets both stages hold their contents.

`timescale 1ns/1ps

module cn_min_tree (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 en_in,
    input  check_node_pkg::llr_vec_t             din,
    input  logic [check_node_pkg::CN_DEGREE-1:0] hard_bits,
    output check_node_pkg::tree_out_t            tree_out,
    output logic                                 tree_valid
);
    import check_node_pkg::*;

    min_pair_t [NUM_PAIRS-1:0] pair_d;
    min_pair_t [NUM_PAIRS-1:0] pair_q;
    logic [NUM_PAIRS-1:0]      sign_par_d;
    logic [NUM_PAIRS-1:0]      hard_par_d;
    logic [NUM_PAIRS-1:0]      sign_par_q;
    logic [NUM_PAIRS-1:0]      hard_par_q;
    logic [CN_DEGREE-1:0]      sign_d;
    logic [CN_DEGREE-1:0]      sign_q;
    logic                      en_d1;
    min_pair_t                 left_merged;

    //////////////////////////////
    // stage 1 pair sort
    //////////////////////////////

    // lower edge of the pair goes first on equal magnitudes
    always_comb begin
        for (int p = 0; p < NUM_PAIRS; p++) begin
            if (din[2*p+1].mag < din[2*p].mag) begin
                pair_d[p].min1 = din[2*p+1].mag;
                pair_d[p].min2 = din[2*p].mag;
                pair_d[p].idx  = IDX_W'(2*p+1);
            end else begin
                pair_d[p].min1 = din[2*p].mag;
                pair_d[p].min2 = din[2*p+1].mag;
                pair_d[p].idx  = IDX_W'(2*p);
            end
            sign_par_d[p] = din[2*p].sign ^ din[2*p+1].sign;
            hard_par_d[p] = hard_bits[2*p] ^ hard_bits[2*p+1];
        end
    end

    // own signs are needed again at the output
    always_comb begin
        for (int e = 0; e < CN_DEGREE; e++) begin
            sign_d[e] = din[e].sign;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pair_q     <= '0;
            sign_par_q <= '0;
            hard_par_q <= '0;
            sign_q     <= '0;
        end else if (en_in) begin
            pair_q     <= pair_d;
            sign_par_q <= sign_par_d;
            hard_par_q <= hard_par_d;
            sign_q     <= sign_d;
        end
    end

    //////////////////////////////
    // stage 2 merge
    //////////////////////////////

    // edges 0 to 3 fold into one result
    cn_min_merge u_merge_left (
        .left   (pair_q[0]),
        .right  (pair_q[1]),
        .merged (left_merged)
    );

    // pair 2 rides along unchanged as the right half
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tree_out <= '0;
        end else if (en_d1) begin
            tree_out.left           <= left_merged;
            tree_out.right          <= pair_q[2];
            tree_out.sign_vec       <= sign_q;
            tree_out.sign_par_left  <= sign_par_q[0] ^ sign_par_q[1];
            tree_out.sign_par_right <= sign_par_q[2];
            tree_out.hard_par_left  <= hard_par_q[0] ^ hard_par_q[1];
            tree_out.hard_par_right <= hard_par_q[2];
        end
    end

    //////////////////////////////
    // enable delay chain
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            en_d1      <= 1'b0;
            tree_valid <= 1'b0;
        end else begin
            en_d1      <= en_in;
            tree_valid <= en_d1;
        end
    end

endmodule

/* testbench/tb_cn_model.svh */
// Reference model, random source and stimulus table for the check node bench.
// Included inside the testbench module after the package import.

`ifndef TB_CN_MODEL_SVH
`define TB_CN_MODEL_SVH

//////////////////////////////
// table types
//////////////////////////////

typedef struct packed {
    int                   test_id;
    logic                 en;
    logic [CN_DEGREE-1:0] hard;
    llr_vec_t             din;
} stim_row_t;

typedef struct packed {
    logic [31:0] row;
    logic        par;
    llr_vec_t    dout;
} expect_t;

stim_row_t   rows[$];
logic [31:0] rng_state = 32'd98;

//////////////////////////////
// reference model
//////////////////////////////

// idx is the lowest edge that holds min1
function automatic llr_vec_t model_dout(input llr_vec_t d, input logic [MAG_W-1:0] offset);
    logic [MAG_W-1:0] min1;
    logic [MAG_W-1:0] min2;
    logic [MAG_W-1:0] other;
    logic             total;
    int               idx;
    llr_vec_t         res;
    min1  = '1;
    total = 1'b0;
    idx   = 0;
    for (int e = 0; e < CN_DEGREE; e++) begin
        if (d[e].mag < min1) begin
            min1 = d[e].mag;
        end
        total = total ^ d[e].sign;
    end
    for (int e = CN_DEGREE - 1; e >= 0; e--) begin
        if (d[e].mag == min1) begin
            idx = e;
        end
    end
    min2 = '1;
    for (int e = 0; e < CN_DEGREE; e++) begin
        if (e != idx && d[e].mag < min2) begin
            min2 = d[e].mag;
        end
    end
    for (int e = 0; e < CN_DEGREE; e++) begin
        other       = (e == idx) ? min2 : min1;
        res[e].mag  = (other > offset) ? other - offset : '0;
        res[e].sign = total ^ d[e].sign;
    end
    return res;
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

function automatic llr_vec_t random_vec();
    logic [31:0] lo;
    logic [31:0] hi;
    lo = next_rand();
    hi = next_rand();
    return {hi[3:0], lo};
endfunction

function automatic logic [CN_DEGREE-1:0] random_hard();
    logic [31:0] r;
    r = next_rand();
    return r[CN_DEGREE-1:0];
endfunction

// mags are listed edge 5 first
function automatic llr_vec_t pack_mags(input logic [CN_DEGREE-1:0][MAG_W-1:0] mags,
                                       input logic [CN_DEGREE-1:0] signs);
    llr_vec_t v;
    for (int e = 0; e < CN_DEGREE; e++) begin
        v[e].mag  = mags[e];
        v[e].sign = signs[e];
    end
    return v;
endfunction

//////////////////////////////
// stimulus table
//////////////////////////////

task automatic add_row(input int tid, input llr_vec_t d, input logic [CN_DEGREE-1:0] h,
                       input logic en);
    stim_row_t row;
    row.test_id = tid;
    row.en      = en;
    row.hard    = h;
    row.din     = d;
    rows.push_back(row);
endtask

// din keeps moving while en_in is low
task automatic add_idle(input int tid, input int n);
    for (int i = 0; i < n; i++) begin
        add_row(tid, random_vec(), random_hard(), 1'b0);
    end
endtask

task automatic build_table();
    logic [15:0] gaps;
    gaps = 16'b0010_0100_0001_1001;
    add_row(1, pack_mags({5'd20, 5'd15, 5'd9, 5'd3, 5'd12, 5'd7}, 6'b100101), 6'b101100, 1'b1);
    add_idle(1, 5);
    // unique minimum with zero and one magnitudes
    add_row(2, pack_mags({5'd8, 5'd25, 5'd2, 5'd17, 5'd4, 5'd10}, 6'b000000), 6'b000001, 1'b1);
    add_row(2, pack_mags({5'd0, 5'd9, 5'd14, 5'd1, 5'd22, 5'd5}, 6'b010010), 6'b110000, 1'b1);
    add_row(2, pack_mags({5'd6, 5'd30, 5'd12, 5'd19, 5'd7, 5'd1}, 6'b111111), 6'b111111, 1'b1);
    add_row(2, pack_mags({5'd31, 5'd31, 5'd31, 5'd31, 5'd0, 5'd31}, 6'b001000), 6'b010101, 1'b1);
    add_idle(2, 2);
    // ties inside a pair, across pairs, everywhere, at zero
    add_row(3, pack_mags({5'd13, 5'd20, 5'd4, 5'd4, 5'd11, 5'd9}, 6'b000110), 6'b000011, 1'b1);
    add_row(3, pack_mags({5'd18, 5'd6, 5'd10, 5'd27, 5'd6, 5'd16}, 6'b101000), 6'b100110, 1'b1);
    add_row(3, pack_mags({5'd15, 5'd15, 5'd15, 5'd15, 5'd15, 5'd15}, 6'b011001), 6'b000000, 1'b1);
    add_row(3, pack_mags({5'd0, 5'd8, 5'd3, 5'd12, 5'd5, 5'd0}, 6'b100001), 6'b111000, 1'b1);
    add_idle(3, 2);
    for (int i = 0; i < 20; i++) begin
        add_row(4, random_vec(), random_hard(), 1'b1);
    end
    add_idle(4, 2);
    for (int i = 0; i < 40; i++) begin
        add_row(5, random_vec(), random_hard(), 1'b1);
    end
    for (int i = 0; i < 16; i++) begin
        add_row(5, random_vec(), random_hard(), gaps[i]);
    end
    add_idle(5, 3);
endtask

`endif

/* testbench/tb_check_node_unit.sv */
// Testbench for check_node_unit at the default offset.
// Outputs are sampled on the falling edge, three falling edges after a row
// is driven, so two rising edges after en_in is sampled.

`timescale 1ns/1ps

module tb_check_node_unit;
    import check_node_pkg::*;

    `include "tb_cn_model.svh"

    logic                 clk;
    logic                 reset_n;
    logic                 en_in;
    llr_vec_t             din;
    logic [CN_DEGREE-1:0] hard_bits;
    llr_vec_t             dout;
    logic                 check_parity;
    logic                 out_valid;

    expect_t  exp_q[$];
    llr_vec_t last_dout;
    logic     last_par;
    int       checks;
    int       errors;
    int       test_errors[6];
    int       cycle_count;
    int       cycle_limit;
    logic     running;
    string    test_name[6] = '{"reset", "isolated", "unique_min", "tied_min",
                               "signs_parity", "back_to_back"};

    check_node_unit i_dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .en_in        (en_in),
        .din          (din),
        .hard_bits    (hard_bits),
        .dout         (dout),
        .check_parity (check_parity),
        .out_valid    (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    task automatic compare_value(input int tid, input string sig, input logic [35:0] got,
                                 input logic [35:0] want);
        checks++;
        assert (got === want) else begin
            $display("ERR %0t %s got %h expected %h", $time, sig, got, want);
            errors++;
            test_errors[tid]++;
        end
    endtask

    task automatic check_true(input int tid, input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            $display("%0t: %s", $time, msg);
            errors++;
            test_errors[tid]++;
        end
    endtask

    // output slot of row j
    task automatic judge_row(input int j);
        int      tid;
        expect_t want;
        tid = rows[j].test_id;
        if (out_valid) begin
            check_true(tid, exp_q.size() > 0, "out_valid pulsed with no result pending");
            if (exp_q.size() > 0) begin
                want = exp_q.pop_front();
                check_true(tid, want.row == 32'(j), "result arrived in the wrong cycle");
                compare_value(tid, "dout", dout, want.dout);
                compare_value(tid, "check_parity", 36'(check_parity), 36'(want.par));
                last_dout = want.dout;
                last_par  = want.par;
            end
        end else begin
            check_true(tid, !rows[j].en, $sformatf("no out_valid pulse for row %0d", j));
            if (rows[j].en && exp_q.size() > 0) begin
                want = exp_q.pop_front();
            end
            compare_value(tid, "dout", dout, last_dout);
            compare_value(tid, "check_parity", 36'(check_parity), 36'(last_par));
        end
        if (j == rows.size() - 1 || rows[j+1].test_id != tid) begin
            $display("test %0d (%s) finished with %0d errors", tid, test_name[tid],
                     test_errors[tid]);
        end
    endtask

    task automatic drive_row(input int k);
        expect_t want;
        if (k < rows.size()) begin
            en_in     = rows[k].en;
            din       = rows[k].din;
            hard_bits = rows[k].hard;
            if (rows[k].en) begin
                want.row  = 32'(k);
                want.dout = model_dout(rows[k].din, NORM_OFFSET_DEFAULT);
                want.par  = ^rows[k].hard;
                exp_q.push_back(want);
            end
        end else begin
            en_in = 1'b0;
        end
    endtask

    //////////////////////////////
    // timeout
    //////////////////////////////

    always @(posedge clk) begin
        if (running) begin
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                $display("timeout: run still going after %0d cycles", cycle_limit);
                $display("TEST FAIL");
                $finish;
            end
        end
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        reset_n     = 1'b0;
        en_in       = 1'b0;
        din         = '0;
        hard_bits   = '0;
        last_dout   = '0;
        last_par    = 1'b0;
        checks      = 0;
        errors      = 0;
        cycle_count = 0;
        running     = 1'b0;
        for (int t = 0; t < 6; t++) begin
            test_errors[t] = 0;
        end
        build_table();
        cycle_limit = rows.size() + 20;

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // everything reads zero out of reset
        compare_value(0, "dout", dout, '0);
        compare_value(0, "check_parity", 36'(check_parity), '0);
        compare_value(0, "out_valid", 36'(out_valid), '0);
        $display("test 0 (%s) finished with %0d errors", test_name[0], test_errors[0]);

        running = 1'b1;
        for (int k = 0; k < rows.size() + 3; k++) begin
            @(negedge clk);
            if (k >= 3) begin
                judge_row(k - 3);
            end
            drive_row(k);
        end
        running = 1'b0;

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
